// File: hw/spim_reg_pkg.sv
// spim register map package with bus offsets, field positions and start bits
package spim_reg_pkg;

    // only the low address byte is decoded
    localparam int ADR_DEC_W = 8;
    // byte enables on the register bus
    localparam int SEL_W = 4;

    // register offsets
    localparam logic [ADR_DEC_W-1:0] REG_CTRL  = 8'h00;
    localparam logic [ADR_DEC_W-1:0] REG_CMD   = 8'h04;
    localparam logic [ADR_DEC_W-1:0] REG_ADDR  = 8'h08;
    localparam logic [ADR_DEC_W-1:0] REG_LEN   = 8'h0C;
    localparam logic [ADR_DEC_W-1:0] REG_WDATA = 8'h10;
    localparam logic [ADR_DEC_W-1:0] REG_RDATA = 8'h14;
    localparam logic [ADR_DEC_W-1:0] REG_START = 8'h18;

    // start register bits
    localparam int START_RD_BIT = 0;
    localparam int START_WR_BIT = 1;

    // length register layout
    localparam int LEN_ADDR_LSB  = 0;
    localparam int LEN_DUMMY_LSB = 8;
    localparam int LEN_DATA_LSB  = 16;

    // control register layout, busy is read only
    localparam int CTRL_DIV_LSB  = 0;
    localparam int CTRL_BUSY_BIT = 8;

endpackage

// File: hw/spim_xfer_pkg.sv
// spim transfer package with phase encoding and field widths
package spim_xfer_pkg;

    // every length field
    localparam int LEN_W = 6;
    // serial clock divider
    localparam int DIV_W = 6;

    // flash command byte
    localparam int CMD_W = 8;
    // address word
    localparam int ADDR_W = 32;
    // read and write data word
    localparam int DATA_W = 32;

    // transfer phases, one after the other
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        CMD   = 3'd1,
        ADDR  = 3'd2,
        DUMMY = 3'd3,
        DATA  = 3'd4,
        DONE  = 3'd5
    } spim_phase_e;

endpackage

// File: hw/spim_cmd_if.sv
// spim command interface carrying one programmed transfer to the sequencer
`timescale 1ns/10ps
interface spim_cmd_if;
    import spim_xfer_pkg::*;

    // request side
    logic               req;
    logic               rd;
    logic               wr;
    logic [CMD_W-1:0]   cmd;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   addr_len;
    logic [LEN_W-1:0]   dummy_len;
    logic [LEN_W-1:0]   data_len;
    logic [DATA_W-1:0]  wdata;

    // completion side
    logic               ack;
    logic [DATA_W-1:0]  rdata;
    logic               busy;

    modport regs (
        output req, rd, wr, cmd, addr, addr_len, dummy_len, data_len, wdata,
        input  ack, rdata, busy
    );

    modport ctrl (
        input  req, rd, wr, cmd, addr, addr_len, dummy_len, data_len, wdata,
        output ack, rdata, busy
    );

endinterface

// File: hw/spim_bit_if.sv
// spim bit interface between the phase sequencer and the pad shifter
`timescale 1ns/10ps
interface spim_bit_if;

    // sequencer side
    logic cs_active;
    logic bit_vld;
    logic bit_out;
    logic drive_en;

    // pad side
    // bit_take also marks the trailing half period once bit_vld is low
    logic bit_take;
    logic bit_in_vld;
    logic bit_in;

    modport ctrl (
        output cs_active, bit_vld, bit_out, drive_en,
        input  bit_take, bit_in_vld, bit_in
    );

    modport phy (
        input  cs_active, bit_vld, bit_out, drive_en,
        output bit_take, bit_in_vld, bit_in
    );

endinterface

// File: hw/spim_regs.sv
// spim register block, decodes bus accesses and launches flash transfers
`timescale 1ns/10ps
module spim_regs #(
    parameter int WB_WIDTH = 32,
    parameter int DIV_W    = spim_xfer_pkg::DIV_W
) (
    input  logic                           mclk,
    input  logic                           rst_n_i,
    input  logic                           wbd_stb_i,
    input  logic [WB_WIDTH-1:0]            wbd_adr_i,
    input  logic                           wbd_we_i,
    input  logic [WB_WIDTH-1:0]            wbd_dat_i,
    input  logic [spim_reg_pkg::SEL_W-1:0] wbd_sel_i,
    output logic [WB_WIDTH-1:0]            wbd_dat_o,
    output logic                           wbd_ack_o,
    output logic                           wbd_err_o,
    output logic [DIV_W-1:0]               clk_div_o,
    spim_cmd_if.regs                       cmd_o
);
    import spim_reg_pkg::*;
    import spim_xfer_pkg::*;

    localparam int NB = WB_WIDTH / 8;

    logic [ADR_DEC_W-1:0] off;
    logic                 new_acc;
    logic                 mapped;
    logic                 start_wr;
    logic                 start_busy;
    logic [WB_WIDTH-1:0]  rd_mux;
    logic [WB_WIDTH-1:0]  wr_word;
    logic [DIV_W-1:0]     div_q;
    logic [CMD_W-1:0]     cmd_q;
    logic [ADDR_W-1:0]    addr_q;
    logic [LEN_W-1:0]     addr_len_q;
    logic [LEN_W-1:0]     dummy_len_q;
    logic [LEN_W-1:0]     data_len_q;
    logic [DATA_W-1:0]    wdata_q;
    logic [DATA_W-1:0]    rdata_q;
    logic                 req_q;
    logic                 rd_q;
    logic                 wr_q;

    // byte lane merge of bus data into the current register word
    function automatic logic [WB_WIDTH-1:0] be_merge(
        input logic [WB_WIDTH-1:0] old_v,
        input logic [WB_WIDTH-1:0] new_v,
        input logic [SEL_W-1:0]    sel
    );
        logic [WB_WIDTH-1:0] res;
        res = old_v;
        for (int i = 0; i < NB; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign off     = wbd_adr_i[ADR_DEC_W-1:0];
    // first cycle of a strobe, ack or err not yet given
    assign new_acc = wbd_stb_i && !wbd_ack_o && !wbd_err_o;
    assign wr_word = be_merge(rd_mux, wbd_dat_i, wbd_sel_i);

    assign start_wr   = new_acc && wbd_we_i && (off == REG_START);
    // no second transfer while one is in flight
    assign start_busy = start_wr && cmd_o.busy;

    // readback, fields right aligned and masked
    always_comb begin
        rd_mux = '0;
        mapped = 1'b1;
        case (off)
            REG_CTRL: begin
                rd_mux[CTRL_DIV_LSB +: DIV_W] = div_q;
                rd_mux[CTRL_BUSY_BIT]         = cmd_o.busy;
            end
            REG_CMD:   rd_mux[CMD_W-1:0]  = cmd_q;
            REG_ADDR:  rd_mux[ADDR_W-1:0] = addr_q;
            REG_LEN: begin
                rd_mux[LEN_ADDR_LSB +: LEN_W]  = addr_len_q;
                rd_mux[LEN_DUMMY_LSB +: LEN_W] = dummy_len_q;
                rd_mux[LEN_DATA_LSB +: LEN_W]  = data_len_q;
            end
            REG_WDATA: rd_mux[DATA_W-1:0] = wdata_q;
            REG_RDATA: rd_mux[DATA_W-1:0] = rdata_q;
            // start reads as zero
            REG_START: mapped = 1'b1;
            default:   mapped = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // bus response and start pulse
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            wbd_ack_o <= 1'b0;
            wbd_err_o <= 1'b0;
            req_q     <= 1'b0;
            rd_q      <= 1'b0;
            wr_q      <= 1'b0;
        end else begin
            wbd_ack_o <= new_acc && mapped && !start_busy;
            wbd_err_o <= new_acc && (!mapped || start_busy);
            req_q     <= 1'b0;
            if (start_wr && !cmd_o.busy && wbd_sel_i[0] &&
                (wbd_dat_i[START_RD_BIT] || wbd_dat_i[START_WR_BIT])) begin
                req_q <= 1'b1;
                rd_q  <= wbd_dat_i[START_RD_BIT];
                wr_q  <= wbd_dat_i[START_WR_BIT];
            end
        end
    end

    // configuration fields
    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            div_q       <= '0;
            cmd_q       <= '0;
            addr_q      <= '0;
            addr_len_q  <= '0;
            dummy_len_q <= '0;
            data_len_q  <= '0;
        end else if (new_acc && wbd_we_i) begin
            case (off)
                REG_CTRL: div_q  <= wr_word[CTRL_DIV_LSB +: DIV_W];
                REG_CMD:  cmd_q  <= wr_word[CMD_W-1:0];
                REG_ADDR: addr_q <= wr_word[ADDR_W-1:0];
                REG_LEN: begin
                    addr_len_q  <= wr_word[LEN_ADDR_LSB +: LEN_W];
                    dummy_len_q <= wr_word[LEN_DUMMY_LSB +: LEN_W];
                    data_len_q  <= wr_word[LEN_DATA_LSB +: LEN_W];
                end
                default: ;
            endcase
        end
    end

    // data words and bus read data
    always_ff @(posedge mclk) begin
        if (new_acc && wbd_we_i && (off == REG_WDATA)) begin
            wdata_q <= wr_word[DATA_W-1:0];
        end
        // read data captured at transfer end
        if (cmd_o.ack) begin
            rdata_q <= cmd_o.rdata;
        end
        if (new_acc) begin
            wbd_dat_o <= rd_mux;
        end
    end

    assign clk_div_o       = div_q;
    assign cmd_o.req       = req_q;
    assign cmd_o.rd        = rd_q;
    assign cmd_o.wr        = wr_q;
    assign cmd_o.cmd       = cmd_q;
    assign cmd_o.addr      = addr_q;
    assign cmd_o.addr_len  = addr_len_q;
    assign cmd_o.dummy_len = dummy_len_q;
    assign cmd_o.data_len  = data_len_q;
    assign cmd_o.wdata     = wdata_q;

endmodule

// File: hw/spim_ctrl.sv
// spim phase sequencer, turns one request into a serial bit stream
`timescale 1ns/10ps
module spim_ctrl (
    input  logic     mclk,
    input  logic     rst_n_i,
    spim_cmd_if.ctrl cmd_i,
    spim_bit_if.ctrl bit_o,
    output logic     eot_o
);
    import spim_xfer_pkg::*;

    spim_phase_e       phase_q;
    // following phase, empty ones skipped
    spim_phase_e       phase_nxt;
    // bits left in the current phase
    logic [LEN_W-1:0]  cnt_q;
    logic [LEN_W-1:0]  load_cnt;
    logic [DATA_W-1:0] sh_q;
    logic [DATA_W-1:0] load_sh;
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic              in_xfer;
    logic              advance;

    //////////////////////////////////////////////////////////////////////
    // phase selection
    //////////////////////////////////////////////////////////////////////

    assign in_xfer = phase_q inside {CMD, ADDR, DUMMY, DATA};
    // start of a request or last bit of a phase taken
    assign advance = (phase_q == IDLE && cmd_i.req) ||
                     (in_xfer && bit_o.bit_take && cnt_q == LEN_W'(1));

    always_comb begin
        if (phase_q == IDLE) begin
            phase_nxt = CMD;
        end else if (phase_q == CMD && cmd_i.addr_len != '0) begin
            phase_nxt = ADDR;
        end else if (phase_q inside {CMD, ADDR} && cmd_i.dummy_len != '0) begin
            phase_nxt = DUMMY;
        end else if (phase_q inside {CMD, ADDR, DUMMY} && cmd_i.data_len != '0) begin
            phase_nxt = DATA;
        end else begin
            phase_nxt = DONE;
        end
    end

    // length and shift word for the phase being entered
    always_comb begin
        load_cnt = '0;
        load_sh  = sh_q;
        case (phase_nxt)
            CMD: begin
                load_cnt = LEN_W'(CMD_W);
                load_sh  = {cmd_i.cmd, {(DATA_W-CMD_W){1'b0}}};
            end
            ADDR: begin
                // left aligned so the msb leaves first
                load_cnt = cmd_i.addr_len;
                load_sh  = DATA_W'(cmd_i.addr) << (ADDR_W - cmd_i.addr_len);
            end
            DUMMY: load_cnt = cmd_i.dummy_len;
            DATA: begin
                load_cnt = cmd_i.data_len;
                load_sh  = cmd_i.wdata << (DATA_W - cmd_i.data_len);
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            phase_q <= IDLE;
            cnt_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            // ack once chip select is released
            ack_q <= (phase_q == DONE) && bit_o.bit_take;
            if (advance) begin
                phase_q <= phase_nxt;
                cnt_q   <= load_cnt;
            end else if (phase_q == DONE && bit_o.bit_take) begin
                phase_q <= IDLE;
            end else if (in_xfer && bit_o.bit_take) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // shift out on falling edges, collect read data on rising edges
    always_ff @(posedge mclk) begin
        if (advance) begin
            sh_q <= load_sh;
        end else if (in_xfer && bit_o.bit_take) begin
            sh_q <= {sh_q[DATA_W-2:0], 1'b0};
        end
        if (advance && phase_nxt == DATA) begin
            rdata_q <= '0;
        end else if (phase_q == DATA && cmd_i.rd && bit_o.bit_in_vld) begin
            rdata_q <= {rdata_q[DATA_W-2:0], bit_o.bit_in};
        end
    end

    assign bit_o.cs_active = (phase_q != IDLE);
    assign bit_o.bit_vld   = in_xfer;
    assign bit_o.bit_out   = sh_q[DATA_W-1];
    // data pin driven for command, address and write data
    assign bit_o.drive_en  = (phase_q inside {CMD, ADDR}) || (phase_q == DATA && cmd_i.wr);

    assign cmd_i.ack   = ack_q;
    assign cmd_i.rdata = rdata_q;
    assign cmd_i.busy  = (phase_q != IDLE);
    assign eot_o       = ack_q;

endmodule

// File: hw/spim_phy.sv
// spim pad shifter, divides mclk into the serial clock and drives the pads
`timescale 1ns/10ps
module spim_phy #(
    parameter int DIV_W = spim_xfer_pkg::DIV_W
) (
    input  logic             mclk,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] clk_div_i,
    spim_bit_if.phy          bit_i,
    input  logic [5:0]       io_in_i,
    output logic [5:0]       io_out_o,
    output logic [5:0]       io_oeb_o
);

    logic [DIV_W-1:0] cnt_q;
    logic             sclk_q;
    logic             csn_q;
    logic             tick;
    logic             rise;
    logic             fall;
    logic             release_cs;
    logic             in_vld_q;
    logic             in_q;

    // one tick per half period of div + 1 cycles
    assign tick       = !csn_q && (cnt_q >= clk_div_i);
    assign rise       = tick && !sclk_q && bit_i.bit_vld;
    assign fall       = tick && sclk_q;
    // trailing half period done with no bit pending
    assign release_cs = tick && !sclk_q && !bit_i.bit_vld;

    always_ff @(posedge mclk) begin
        if (!rst_n_i) begin
            cnt_q    <= '0;
            sclk_q   <= 1'b0;
            csn_q    <= 1'b1;
            in_vld_q <= 1'b0;
        end else begin
            in_vld_q <= rise;
            // counter held while deselected
            if (csn_q || tick) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            // select one half period ahead of the first rising edge
            if (csn_q && bit_i.cs_active) begin
                csn_q <= 1'b0;
            end else if (release_cs) begin
                csn_q <= 1'b1;
            end
            if (rise) begin
                sclk_q <= 1'b1;
            end else if (fall) begin
                sclk_q <= 1'b0;
            end
        end
    end

    // flash data in sampled at the rising edge
    always_ff @(posedge mclk) begin
        if (rise) begin
            in_q <= io_in_i[3];
        end
    end

    assign bit_i.bit_take   = fall || release_cs;
    assign bit_i.bit_in_vld = in_vld_q;
    assign bit_i.bit_in     = in_q;

    // pad order clk, csn, sdo, unused
    assign io_out_o = {3'b000, bit_i.bit_out, csn_q, sclk_q};
    assign io_oeb_o = {3'b111, !bit_i.drive_en, 1'b0, 1'b0};

endmodule

// File: hw/spim_top.sv
// spim top level, single lane flash master behind a register bus
`timescale 1ns/10ps
module spim_top #(
    parameter int WB_WIDTH = 32,
    parameter int DIV_W    = spim_xfer_pkg::DIV_W
) (
    input  logic                mclk,
    input  logic                rst_n_i,
    input  logic                wbd_stb_i,
    input  logic [WB_WIDTH-1:0] wbd_adr_i,
    input  logic                wbd_we_i,
    input  logic [WB_WIDTH-1:0] wbd_dat_i,
    input  logic [3:0]          wbd_sel_i,
    output logic [WB_WIDTH-1:0] wbd_dat_o,
    output logic                wbd_ack_o,
    output logic                wbd_err_o,
    output logic [1:0]          events_o,
    input  logic [5:0]          io_in_i,
    output logic [5:0]          io_out_o,
    output logic [5:0]          io_oeb_o
);

    logic [DIV_W-1:0] clk_div;
    logic             eot;

    spim_cmd_if cmd_if ();
    spim_bit_if bit_if ();

    spim_regs #(
        .WB_WIDTH (WB_WIDTH),
        .DIV_W    (DIV_W)
    ) u_spim_regs (
        .mclk      (mclk),
        .rst_n_i   (rst_n_i),
        .wbd_stb_i (wbd_stb_i),
        .wbd_adr_i (wbd_adr_i),
        .wbd_we_i  (wbd_we_i),
        .wbd_dat_i (wbd_dat_i),
        .wbd_sel_i (wbd_sel_i),
        .wbd_dat_o (wbd_dat_o),
        .wbd_ack_o (wbd_ack_o),
        .wbd_err_o (wbd_err_o),
        .clk_div_o (clk_div),
        .cmd_o     (cmd_if.regs)
    );

    spim_ctrl u_spim_ctrl (
        .mclk    (mclk),
        .rst_n_i (rst_n_i),
        .cmd_i   (cmd_if.ctrl),
        .bit_o   (bit_if.ctrl),
        .eot_o   (eot)
    );

    spim_phy #(
        .DIV_W (DIV_W)
    ) u_spim_phy (
        .mclk      (mclk),
        .rst_n_i   (rst_n_i),
        .clk_div_i (clk_div),
        .bit_i     (bit_if.phy),
        .io_in_i   (io_in_i),
        .io_out_o  (io_out_o),
        .io_oeb_o  (io_oeb_o)
    );

    // end of transfer pulse and busy level
    assign events_o = {cmd_if.busy, eot};

endmodule

// File: sim/spim_properties.sv
// spim pad protocol checks, bound to the top level
`timescale 1ns/10ps
module spim_properties (
    input logic       mclk,
    input logic       rst_n_i,
    input logic [1:0] events_o,
    input logic [5:0] io_out_o,
    input logic [5:0] io_oeb_o
);

    // failed assertion count, read by the testbench at the end
    int fail_cnt = 0;

    // serial clock parked low while deselected
    sclk_idle_low: assert property (@(posedge mclk) disable iff (!rst_n_i)
        io_out_o[1] |-> !io_out_o[0])
        else begin
            fail_cnt++;
            $error("serial clock high while chip select is high");
        end

    // clock and chip select pads always driven
    ctrl_pads_driven: assert property (@(posedge mclk) disable iff (!rst_n_i)
        io_oeb_o[1:0] == 2'b00)
        else begin
            fail_cnt++;
            $error("clock or chip select pad not driven");
        end

    // end of transfer is one cycle wide
    eot_single: assert property (@(posedge mclk) disable iff (!rst_n_i)
        events_o[0] |=> !events_o[0])
        else begin
            fail_cnt++;
            $error("end of transfer pulse longer than one cycle");
        end

endmodule

bind spim_top spim_properties i_props (.*);

// File: sim/tb_spim_top.sv
// spim testbench, directed transfers against a serial flash responder
`timescale 1ns/10ps
module tb_spim_top;
    import spim_reg_pkg::*;
    import spim_xfer_pkg::*;

    // run limit, two worst case transfers per test slot plus bus traffic
    localparam int N_XFER    = 7;
    localparam int MAX_BITS  = 8 + 32 + 8 + 32;
    localparam int MAX_DIV   = 3;
    localparam int BUS_OVH   = 600;
    localparam int CYC_LIMIT = 2 * N_XFER * MAX_BITS * 2 * (MAX_DIV + 1) + BUS_OVH;

    logic        mclk;
    logic        rst_n_i;
    logic        wbd_stb_i;
    logic [31:0] wbd_adr_i;
    logic        wbd_we_i;
    logic [31:0] wbd_dat_i;
    logic [3:0]  wbd_sel_i;
    logic [31:0] wbd_dat_o;
    logic        wbd_ack_o;
    logic        wbd_err_o;
    logic [1:0]  events_o;
    logic [5:0]  io_in_i;
    logic [5:0]  io_out_o;
    logic [5:0]  io_oeb_o;

    int          err_cnt;
    int          chk_cnt;
    int          cyc_cnt;
    int          eot_cnt;
    logic [15:0] lfsr_q;
    // expected transfer, also steers the flash model
    logic [7:0]  exp_cmd;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic        exp_rd;
    int          exp_al;
    int          exp_dl;
    int          exp_ddl;
    logic [31:0] resp_word;
    // flash side capture
    logic        cap_bits[$];
    logic        oeb_bits[$];
    int          rise_cnt;
    time         last_edge;
    time         half_min;
    time         half_max;

    spim_top i_dut (
        .mclk      (mclk),
        .rst_n_i   (rst_n_i),
        .wbd_stb_i (wbd_stb_i),
        .wbd_adr_i (wbd_adr_i),
        .wbd_we_i  (wbd_we_i),
        .wbd_dat_i (wbd_dat_i),
        .wbd_sel_i (wbd_sel_i),
        .wbd_dat_o (wbd_dat_o),
        .wbd_ack_o (wbd_ack_o),
        .wbd_err_o (wbd_err_o),
        .events_o  (events_o),
        .io_in_i   (io_in_i),
        .io_out_o  (io_out_o),
        .io_oeb_o  (io_oeb_o)
    );

    always #50 mclk = ~mclk;

    always @(posedge mclk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("timeout, run did not finish within %0d mclk cycles", CYC_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // end of transfer pulses, sampled mid cycle
    always @(negedge mclk) begin
        if (events_o[0] === 1'b1) begin
            eot_cnt++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // flash responder
    //////////////////////////////////////////////////////////////////////

    function automatic void note_edge();
        time dt;
        dt = $time - last_edge;
        if (dt < half_min) half_min = dt;
        if (dt > half_max) half_max = dt;
        last_edge = $time;
    endfunction

    // new frame at chip select fall
    always @(negedge io_out_o[1]) begin
        cap_bits.delete();
        oeb_bits.delete();
        rise_cnt  = 0;
        half_min  = '1;
        half_max  = 0;
        last_edge = $time;
    end

    always @(posedge io_out_o[0]) begin
        cap_bits.push_back(io_out_o[2]);
        oeb_bits.push_back(io_oeb_o[2]);
        rise_cnt++;
        note_edge();
    end

    // response bits go out after command, address and dummy
    always @(negedge io_out_o[0]) begin
        if (io_out_o[1] === 1'b0) begin
            note_edge();
            if (rise_cnt >= 8 + exp_al + exp_dl && rise_cnt < 8 + exp_al + exp_dl + exp_ddl) begin
                io_in_i[3] <= resp_word[exp_ddl - 1 - (rise_cnt - 8 - exp_al - exp_dl)];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic [31:0] mask_of(input int n);
        return (n >= 32) ? 32'hFFFF_FFFF : ((32'd1 << n) - 32'd1);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        assert (got === exp) else begin
            $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int e0);
        if (err_cnt == e0) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s failed with %0d errors", name, err_cnt - e0);
        end
    endtask

    // strobe held until ack or err, sampled on the falling edge
    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic exp_err);
        @(posedge mclk);
        wbd_stb_i <= 1'b1;
        wbd_we_i  <= 1'b1;
        wbd_adr_i <= adr;
        wbd_dat_i <= dat;
        wbd_sel_i <= 4'hF;
        do begin
            @(negedge mclk);
        end while (!wbd_ack_o && !wbd_err_o);
        check_eq(wbd_err_o, exp_err, "bus write err flag");
        @(posedge mclk);
        wbd_stb_i <= 1'b0;
        wbd_we_i  <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat, input logic exp_err);
        @(posedge mclk);
        wbd_stb_i <= 1'b1;
        wbd_we_i  <= 1'b0;
        wbd_adr_i <= adr;
        wbd_sel_i <= 4'hF;
        do begin
            @(negedge mclk);
        end while (!wbd_ack_o && !wbd_err_o);
        check_eq(wbd_err_o, exp_err, "bus read err flag");
        dat = wbd_dat_o;
        @(posedge mclk);
        wbd_stb_i <= 1'b0;
    endtask

    task automatic wait_eot();
        do begin
            @(negedge mclk);
        end while (events_o[0] !== 1'b1);
    endtask

    task automatic program_xfer(input int div, input logic [7:0] cmd, input logic [31:0] addr,
                                input int al, input int dl, input int ddl, input logic rd);
        exp_cmd   = cmd;
        exp_addr  = addr;
        exp_al    = al;
        exp_dl    = dl;
        exp_ddl   = ddl;
        exp_rd    = rd;
        exp_wdata = rand_word(32);
        resp_word = rand_word(ddl);
        bus_write(REG_CTRL, div, 1'b0);
        bus_write(REG_CMD, cmd, 1'b0);
        bus_write(REG_ADDR, addr, 1'b0);
        bus_write(REG_LEN, (ddl << LEN_DATA_LSB) | (dl << LEN_DUMMY_LSB) | (al << LEN_ADDR_LSB),
                  1'b0);
        bus_write(REG_WDATA, exp_wdata, 1'b0);
    endtask

    // pin stream split into phases, msb first in each
    task automatic check_xfer();
        logic [31:0] got_cmd;
        logic [31:0] got_addr;
        logic [31:0] got_data;
        logic [31:0] rd_v;
        logic        oeb_ok;
        logic        exp_oeb;
        int          n;
        got_cmd  = '0;
        got_addr = '0;
        got_data = '0;
        oeb_ok   = 1'b1;
        n        = 8 + exp_al + exp_dl + exp_ddl;
        check_eq(rise_cnt, n, "serial clock periods");
        if (cap_bits.size() == n) begin
            for (int i = 0; i < n; i++) begin
                if (i < 8) begin
                    got_cmd = {got_cmd[30:0], cap_bits[i]};
                end else if (i < 8 + exp_al) begin
                    got_addr = {got_addr[30:0], cap_bits[i]};
                end else if (i >= 8 + exp_al + exp_dl) begin
                    got_data = {got_data[30:0], cap_bits[i]};
                end
                // released for dummy, and for data on a read
                exp_oeb = (i >= 8 + exp_al) && (i < 8 + exp_al + exp_dl || exp_rd);
                if (oeb_bits[i] !== exp_oeb) oeb_ok = 1'b0;
            end
            check_eq(got_cmd, exp_cmd, "command bits");
            check_eq(got_addr, exp_addr & mask_of(exp_al), "address bits");
            check_eq(oeb_ok, 1'b1, "data pin direction");
            if (!exp_rd) begin
                check_eq(got_data, exp_wdata & mask_of(exp_ddl), "write data bits");
            end
        end
        if (exp_rd) begin
            bus_read(REG_RDATA, rd_v, 1'b0);
            check_eq(rd_v, resp_word & mask_of(exp_ddl), "read data");
        end
    endtask

    task automatic run_xfer(input int div, input logic [7:0] cmd, input logic [31:0] addr,
                            input int al, input int dl, input int ddl, input logic rd);
        program_xfer(div, cmd, addr, al, dl, ddl, rd);
        bus_write(REG_START, rd ? 32'(1 << START_RD_BIT) : 32'(1 << START_WR_BIT), 1'b0);
        wait_eot();
        check_xfer();
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        int e0;
        e0 = err_cnt;
        @(negedge mclk);
        // deselected, clock parked low, data pin and spare pins released
        check_eq(io_out_o[1:0], 2'b10, "chip select and clock after reset");
        check_eq(io_oeb_o, 6'b111100, "pad enables after reset");
        check_eq({wbd_ack_o, wbd_err_o, events_o}, 4'b0000, "ack, err and events after reset");
        report_test("reset values", e0);
    endtask

    task automatic test_regs();
        logic [31:0] v;
        logic [31:0] got;
        logic [31:0] lenm;
        int          e0;
        e0   = err_cnt;
        lenm = (mask_of(LEN_W) << LEN_DATA_LSB) | (mask_of(LEN_W) << LEN_DUMMY_LSB) |
               (mask_of(LEN_W) << LEN_ADDR_LSB);
        v = rand_word(32);
        bus_write(REG_CTRL, v, 1'b0);
        bus_read(REG_CTRL, got, 1'b0);
        // busy reads low when idle
        check_eq(got, v & (mask_of(DIV_W) << CTRL_DIV_LSB), "ctrl readback");
        v = rand_word(32);
        bus_write(REG_CMD, v, 1'b0);
        bus_read(REG_CMD, got, 1'b0);
        check_eq(got, v & mask_of(8), "cmd readback");
        v = rand_word(32);
        bus_write(REG_ADDR, v, 1'b0);
        bus_read(REG_ADDR, got, 1'b0);
        check_eq(got, v, "addr readback");
        v = rand_word(32);
        bus_write(REG_LEN, v, 1'b0);
        bus_read(REG_LEN, got, 1'b0);
        check_eq(got, v & lenm, "len readback");
        v = rand_word(32);
        bus_write(REG_WDATA, v, 1'b0);
        bus_read(REG_WDATA, got, 1'b0);
        check_eq(got, v, "wdata readback");
        // unmapped offsets
        bus_read(32'h1C, got, 1'b1);
        bus_write(32'h20, v, 1'b1);
        report_test("register readback", e0);
    endtask

    task automatic test_write();
        int e0;
        e0 = err_cnt;
        run_xfer(1, 8'h02, rand_word(32), 24, 4, 32, 1'b0);
        report_test("write transfer", e0);
    endtask

    task automatic test_read();
        int e0;
        e0 = err_cnt;
        run_xfer(1, 8'h0B, rand_word(32), 24, 8, 20, 1'b1);
        report_test("read transfer", e0);
    endtask

    task automatic test_divider();
        int e0;
        e0 = err_cnt;
        run_xfer(0, 8'h03, rand_word(32), 8, 0, 8, 1'b1);
        check_eq(32'(half_min), 100, "shortest half period, div 0");
        check_eq(32'(half_max), 100, "longest half period, div 0");
        run_xfer(3, 8'h03, rand_word(32), 8, 0, 8, 1'b1);
        check_eq(32'(half_min), 400, "shortest half period, div 3");
        check_eq(32'(half_max), 400, "longest half period, div 3");
        report_test("divider", e0);
    endtask

    task automatic test_busy_guard();
        int e0;
        int n0;
        e0 = err_cnt;
        program_xfer(2, 8'h9F, 32'h0, 0, 0, 24, 1'b1);
        n0 = eot_cnt;
        bus_write(REG_START, 32'(1 << START_RD_BIT), 1'b0);
        @(negedge mclk);
        check_eq(events_o[1], 1'b1, "busy after start");
        // second start while busy
        bus_write(REG_START, 32'(1 << START_RD_BIT), 1'b1);
        wait_eot();
        check_xfer();
        repeat (40) @(negedge mclk);
        check_eq(eot_cnt - n0, 1, "end of transfer pulses");
        report_test("busy guard", e0);
    endtask

    task automatic test_no_addr_dummy();
        int e0;
        e0 = err_cnt;
        run_xfer(0, 8'h05, rand_word(32), 0, 0, 16, 1'b1);
        run_xfer(0, 8'h06, rand_word(32), 0, 0, 8, 1'b0);
        report_test("no address or dummy", e0);
    endtask

    initial begin
        mclk      = 1'b0;
        rst_n_i   = 1'b0;
        wbd_stb_i = 1'b0;
        wbd_adr_i = '0;
        wbd_we_i  = 1'b0;
        wbd_dat_i = '0;
        wbd_sel_i = '0;
        io_in_i   = '0;
        err_cnt   = 0;
        chk_cnt   = 0;
        cyc_cnt   = 0;
        eot_cnt   = 0;
        lfsr_q    = 16'd33;
        exp_al    = 0;
        exp_dl    = 0;
        exp_ddl   = 0;
        rise_cnt  = 0;
        repeat (16) @(posedge mclk);
        rst_n_i <= 1'b1;
        test_reset_values();
        test_regs();
        test_write();
        test_read();
        test_divider();
        test_busy_guard();
        test_no_addr_dummy();
        $display("tests 7, checks %0d, errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, i_dut.i_props.fail_cnt);
        if (err_cnt == 0 && i_dut.i_props.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/spim_reg_pkg.sv
hw/spim_xfer_pkg.sv
hw/spim_cmd_if.sv
hw/spim_bit_if.sv
hw/spim_regs.sv
hw/spim_ctrl.sv
hw/spim_phy.sv
hw/spim_top.sv
sim/spim_properties.sv
sim/tb_spim_top.sv
